// File: hw/loader_defines.svh
// Widths assume 8 MB banks split into 16 KB pages; host indices follow the menu download slots
`ifndef LOADER_DEFINES_SVH
`define LOADER_DEFINES_SVH

////////////////////////////////
// Widths
////////////////////////////////

`define LDR_HOST_ADDR_W 25 // Byte address of a host download
`define LDR_MEM_ADDR_W  23 // Address inside one bank
`define LDR_BLOCK_W     14 // 16 KB block offset
`define LDR_PAGE_W      9  // Top bit picks the upper-ROM half
`define LDR_ROM_MAP_W   256

////////////////////////////////
// Host download slots
////////////////////////////////

`define LDR_IDX_ROM 8'd0
`define LDR_IDX_EXT 8'd3

////////////////////////////////
// Fixed pages
////////////////////////////////

`define LDR_PAGE_OS     9'h000
`define LDR_PAGE_BASIC  9'h100
`define LDR_PAGE_AMSDOS 9'h107
`define LDR_PAGE_MF2    9'h0FF
`define LDR_PAGE_BAD    9'h1EE // Unused page, lands malformed extensions
`define LDR_PAGE_COMBO  9'h1FF

`endif

// File: hw/loader_pkg.sv
// Shared loader types; field widths come from the defines header and must stay in step with it
`default_nettype none

package loader_pkg;

`include "loader_defines.svh"

	////////////////////////////////
	// Download classification
	////////////////////////////////

	typedef enum logic [1:0] {
		LOAD_NONE,
		LOAD_ROM,
		LOAD_EXT
	} load_kind_e;

	////////////////////////////////
	// Stage payloads
	////////////////////////////////

	// One host byte as delivered
	typedef struct packed {
		logic [`LDR_HOST_ADDR_W-1:0] addr;
		logic [7:0]                  data;
	} host_beat_t;

	// Expansion ROM placement, decoded from the extension
	typedef struct packed {
		logic [`LDR_PAGE_W-1:0] page;
		logic                   combo; // Jump to the combo page after block 0
	} ext_cfg_t;

	// Intake to address map
	typedef struct packed {
		load_kind_e kind;
		logic       new_file; // First byte of a download
		logic       model;    // 664 when set
		ext_cfg_t   ext;
		host_beat_t host;
	} load_beat_t;

	// Address map to memory port
	typedef struct packed {
		logic [1:0]                 bank;
		logic [`LDR_MEM_ADDR_W-1:0] addr;
		logic [7:0]                 data;
	} mem_cmd_t;

endpackage

`default_nettype wire

// File: hw/loader_intake.sv
// Host holds index, extension and model steady during a download and never has a request open when it starts
`timescale 1ns/1ps
`default_nettype none
`include "loader_defines.svh"

module loader_intake (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire                    host_download,
	input  wire [7:0]              host_index,
	input  wire [15:0]             host_ext,   // Last two extension characters
	input  wire                    model_664,
	input  wire                    host_req,
	input  wire loader_pkg::host_beat_t host_beat,
	output logic                   host_ack,
	output loader_pkg::load_beat_t beat_out,
	output logic                   beat_valid,
	input  wire                    beat_stall
);

	import loader_pkg::*;

	logic       download_q;
	load_kind_e kind_q;
	logic       model_q;
	ext_cfg_t   ext_q;
	ext_cfg_t   ext_dec;
	logic       first_q;   // Next forwarded byte opens the file
	logic [4:0] hex_hi;
	logic [4:0] hex_lo;
	logic       is_start;
	logic       take;

	// Valid flag on top, nibble below
	function automatic logic [4:0] hex_digit(input logic [7:0] c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9")
			r = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			r = {1'b1, c[3:0] + 4'd9};
		return r;
	endfunction

	assign hex_hi = hex_digit(host_ext[15:8]);
	assign hex_lo = hex_digit(host_ext[7:0]);

	always_comb begin
		ext_dec.page  = `LDR_PAGE_BAD;
		ext_dec.combo = 1'b0;
		if (hex_hi[4]) ext_dec.page[7:4] = hex_hi[3:0];
		if (hex_lo[4]) ext_dec.page[3:0] = hex_lo[3:0];
		if (host_ext == "ZZ") ext_dec.page = '0;
		if (host_ext == "Z0") begin
			ext_dec.page  = '0;
			ext_dec.combo = 1'b1;
		end
	end

	assign is_start = host_download && !download_q;
	assign take     = host_req && !host_ack && (!beat_valid || !beat_stall); // Room downstream

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q <= 1'b0;
			kind_q     <= LOAD_NONE;
			first_q    <= 1'b0;
			host_ack   <= 1'b0;
			beat_valid <= 1'b0;
		end else begin
			download_q <= host_download;
			if (is_start) begin
				first_q <= 1'b1;
				if (host_index == `LDR_IDX_ROM)      kind_q <= LOAD_ROM;
				else if (host_index == `LDR_IDX_EXT) kind_q <= LOAD_EXT;
				else                                 kind_q <= LOAD_NONE;
			end else if (!host_download) begin
				kind_q <= LOAD_NONE;
			end
			if (take) begin
				host_ack   <= 1'b1;
				beat_valid <= (kind_q != LOAD_NONE); // Other downloads are only acked
				if (kind_q != LOAD_NONE) first_q <= 1'b0;
			end else begin
				if (!host_req)   host_ack   <= 1'b0;
				if (!beat_stall) beat_valid <= 1'b0;
			end
		end
	end

	// Download settings and the outgoing beat
	always_ff @(posedge clk_sys) begin
		if (is_start) begin
			model_q <= model_664;
			ext_q   <= ext_dec;
		end
		if (take) begin
			beat_out.kind     <= kind_q;
			beat_out.new_file <= first_q;
			beat_out.model    <= model_q;
			beat_out.ext      <= ext_q;
			beat_out.host     <= host_beat;
		end
	end

endmodule

`default_nettype wire

// File: hw/loader_addr_map.sv
// ROM images past block 7 are dropped; rom_map only clears on reset and accumulates across downloads
`timescale 1ns/1ps
`default_nettype none
`include "loader_defines.svh"

module loader_addr_map (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire loader_pkg::load_beat_t beat_in,
	input  wire                        beat_valid,
	output logic                       beat_stall,
	output loader_pkg::mem_cmd_t       cmd_out,
	output logic                       cmd_valid,
	input  wire                        cmd_stall,
	output logic [`LDR_ROM_MAP_W-1:0]  rom_map
);

	import loader_pkg::*;

	logic [`LDR_PAGE_W-1:0]                  page_q;
	logic                                    combo_q;
	logic [`LDR_PAGE_W-1:0]                  cur_page;
	logic                                    cur_combo;
	logic [`LDR_BLOCK_W-1:0]                 offset;
	logic [`LDR_HOST_ADDR_W-`LDR_BLOCK_W-1:0] blk;
	logic [`LDR_PAGE_W-1:0]                  map_page;
	logic [1:0]                              map_bank;
	logic                                    map_keep;
	logic                                    take;

	assign beat_stall = cmd_valid && cmd_stall;
	assign take       = beat_valid && !beat_stall;

	// A new file brings its own page setup
	assign cur_page  = beat_in.new_file ? beat_in.ext.page : page_q;
	assign cur_combo = beat_in.new_file ? beat_in.ext.combo : combo_q;

	assign offset = beat_in.host.addr[`LDR_BLOCK_W-1:0];
	assign blk    = beat_in.host.addr[`LDR_HOST_ADDR_W-1:`LDR_BLOCK_W];

	////////////////////////////////
	// Page and bank decode
	////////////////////////////////

	// Lower half of a bank holds OS, RAM and MF2; upper half the 256 ROM pages
	always_comb begin
		map_page = '1;
		map_bank = 2'd0;
		map_keep = 1'b0;
		if (beat_in.kind == LOAD_EXT) begin
			map_page = {cur_page[8], cur_page[7:0] + blk[7:0]};
			map_bank = {1'b0, beat_in.model};
			map_keep = 1'b1;
		end else if (beat_in.kind == LOAD_ROM && blk < 'd8) begin
			// 6128 set in blocks 0 to 3, 664 set in 4 to 7
			map_bank = {1'b0, blk[2]};
			map_keep = 1'b1;
			case (blk[1:0])
				2'd0:    map_page = `LDR_PAGE_OS;
				2'd1:    map_page = `LDR_PAGE_BASIC;
				2'd2:    map_page = `LDR_PAGE_AMSDOS;
				default: map_page = `LDR_PAGE_MF2;
			endcase
		end
	end

	////////////////////////////////
	// State and output
	////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_q    <= '0;
			combo_q   <= 1'b0;
			cmd_valid <= 1'b0;
			rom_map   <= '0;
		end else begin
			if (take) begin
				page_q    <= cur_page;
				combo_q   <= cur_combo;
				cmd_valid <= map_keep;
				if (cur_combo && &offset) begin // Last byte of the block
					page_q  <= `LDR_PAGE_COMBO;
					combo_q <= 1'b0;
				end
				if (map_keep && map_page[8])
					rom_map[map_page[7:0]] <= 1'b1;
			end else if (!cmd_stall) begin
				cmd_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take) begin
			cmd_out.bank <= map_bank;
			cmd_out.addr <= {map_page, offset};
			cmd_out.data <= beat_in.host.data;
		end
	end

endmodule

`default_nettype wire

// File: hw/loader_mem_port.sv
// Memory must follow the four-phase rule; one command at a time, so throughput is set by the ack latency
`timescale 1ns/1ps
`default_nettype none

module loader_mem_port (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire loader_pkg::mem_cmd_t cmd_in,
	input  wire                      cmd_valid,
	output logic                     cmd_stall,
	output logic                     mem_req,
	output loader_pkg::mem_cmd_t     mem_cmd,
	input  wire                      mem_ack
);

	////////////////////////////////
	// Transfer FSM
	////////////////////////////////

	typedef enum logic [1:0] {
		IDLE,    // Ready for a command
		REQ,     // Request open, waiting for ack
		RELEASE  // Request dropped, waiting for ack to fall
	} port_state_e;

	port_state_e state;
	logic        take;

	assign cmd_stall = (state != IDLE);
	assign take      = cmd_valid && !cmd_stall;
	assign mem_req   = (state == REQ);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (take) state <= REQ;
				end
				REQ: begin
					if (mem_ack) state <= RELEASE;
				end
				RELEASE: begin
					if (!mem_ack) state <= IDLE; // Four phases done
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Held from the rise of req until ack has fallen
	always_ff @(posedge clk_sys) begin
		if (take) mem_cmd <= cmd_in;
	end

endmodule

`default_nettype wire

// File: hw/amstrad_loader.sv
// Boot loader top; host and memory sides are both four-phase req/ack, stages in between use valid/stall
`timescale 1ns/1ps
`default_nettype none
`include "loader_defines.svh"

module amstrad_loader (
	input  wire                        clk_sys,
	input  wire                        reset,
	// Host side
	input  wire                        host_download,
	input  wire [7:0]                  host_index,
	input  wire [15:0]                 host_ext,
	input  wire                        model_664,
	input  wire                        host_req,
	input  wire loader_pkg::host_beat_t host_beat,
	output logic                       host_ack,
	// Memory side
	output logic                       mem_req,
	output loader_pkg::mem_cmd_t       mem_cmd,
	input  wire                        mem_ack,
	output logic [`LDR_ROM_MAP_W-1:0]  rom_map  // Upper-ROM pages present
);

	import loader_pkg::*;

	load_beat_t beat;
	logic       beat_valid;
	logic       beat_stall;
	mem_cmd_t   cmd;
	logic       cmd_valid;
	logic       cmd_stall;

	loader_intake u_intake (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.host_download (host_download),
		.host_index    (host_index),
		.host_ext      (host_ext),
		.model_664     (model_664),
		.host_req      (host_req),
		.host_beat     (host_beat),
		.host_ack      (host_ack),
		.beat_out      (beat),
		.beat_valid    (beat_valid),
		.beat_stall    (beat_stall)
	);

	loader_addr_map u_addr_map (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.beat_in    (beat),
		.beat_valid (beat_valid),
		.beat_stall (beat_stall),
		.cmd_out    (cmd),
		.cmd_valid  (cmd_valid),
		.cmd_stall  (cmd_stall),
		.rom_map    (rom_map)
	);

	loader_mem_port u_mem_port (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cmd_in    (cmd),
		.cmd_valid (cmd_valid),
		.cmd_stall (cmd_stall),
		.mem_req   (mem_req),
		.mem_cmd   (mem_cmd),
		.mem_ack   (mem_ack)
	);

endmodule

`default_nettype wire

// File: test/loader_assertions.sv
// Checks only the four-phase rules at the host and memory boundaries; disabled during reset
`timescale 1ns/1ps
`default_nettype none

module loader_assertions (
	input wire                         clk_sys,
	input wire                         reset,
	input wire                         host_req,
	input wire                         host_ack,
	input wire loader_pkg::host_beat_t host_beat,
	input wire                         mem_req,
	input wire                         mem_ack,
	input wire loader_pkg::mem_cmd_t   mem_cmd
);

	//////////////////////////////
	// Host side
	//////////////////////////////

	property host_beat_held;
		@(posedge clk_sys) disable iff (reset)
		(host_req && !host_ack) |=> $stable(host_beat); // Byte waits for its ack
	endproperty

	//////////////////////////////
	// Memory side
	//////////////////////////////

	property mem_cmd_held;
		@(posedge clk_sys) disable iff (reset)
		(mem_req && $past(mem_req)) |-> $stable(mem_cmd);
	endproperty

	// New request only after the last ack has fallen
	property mem_req_waits_ack;
		@(posedge clk_sys) disable iff (reset)
		$rose(mem_req) |-> !mem_ack;
	endproperty

	assert property (host_beat_held) else $error("host_beat changed before host_ack rose");
	assert property (mem_cmd_held) else $error("mem_cmd changed while mem_req was high");
	assert property (mem_req_waits_ack) else $error("mem_req rose while mem_ack was high");

endmodule

bind amstrad_loader loader_assertions u_assertions (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.host_req  (host_req),
	.host_ack  (host_ack),
	.host_beat (host_beat),
	.mem_req   (mem_req),
	.mem_ack   (mem_ack),
	.mem_cmd   (mem_cmd)
);

`default_nettype wire

// File: test/tb_amstrad_loader.sv
// One fixed download table; memory reply delays are pseudo-random but repeat for the fixed seed
`timescale 1ns/1ps
`default_nettype none
`include "loader_defines.svh"

module tb_amstrad_loader;

	import loader_pkg::*;

	localparam int CYCLES_PER_ENTRY = 60; // Download setup, handshake and slowest memory reply

	typedef struct packed {
		logic                        new_dl; // Open a new download before this byte
		logic [7:0]                  index;
		logic [15:0]                 ext;
		logic                        model;
		logic [`LDR_HOST_ADDR_W-1:0] addr;
		logic [7:0]                  data;
		logic                        drop;   // No memory command expected
		logic [1:0]                  bank;
		logic [`LDR_PAGE_W-1:0]      page;
	} stim_t;

	logic                      clk_sys = 1'b0;
	logic                      reset;
	logic                      host_download;
	logic [7:0]                host_index;
	logic [15:0]               host_ext;
	logic                      model_664;
	logic                      host_req;
	host_beat_t                host_beat;
	logic                      host_ack;
	logic                      mem_req;
	mem_cmd_t                  mem_cmd;
	logic                      mem_ack;
	logic [`LDR_ROM_MAP_W-1:0] rom_map;

	stim_t                     stim_q[$];
	mem_cmd_t                  exp_q[$];
	mem_cmd_t                  got_q[$]; // Filled by the memory model
	logic [`LDR_ROM_MAP_W-1:0] exp_map;
	int                        n_checked = 0;
	int                        limit;
	integer                    seed = 32'h4020_f766;

	amstrad_loader DUT (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.host_download (host_download),
		.host_index    (host_index),
		.host_ext      (host_ext),
		.model_664     (model_664),
		.host_req      (host_req),
		.host_beat     (host_beat),
		.host_ack      (host_ack),
		.mem_req       (mem_req),
		.mem_cmd       (mem_cmd),
		.mem_ack       (mem_ack),
		.rom_map       (rom_map)
	);

	always #10 clk_sys = ~clk_sys;

	task automatic stop_run();
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error %s: got %0h, expected %0h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic add_entry(input logic new_dl, input logic [7:0] index, input logic [15:0] ext,
			input logic model, input logic [`LDR_HOST_ADDR_W-1:0] addr, input logic [7:0] data,
			input logic drop, input logic [1:0] bank, input logic [`LDR_PAGE_W-1:0] page);
		stim_q.push_back({new_dl, index, ext, model, addr, data, drop, bank, page});
	endtask

	//////////////////////////////
	// Stimulus table
	//////////////////////////////

	task automatic load_table();
		// ROM image, 6128 set in blocks 0 to 3, 664 set in 4 to 7
		add_entry(1'b1, 8'd0, "  ", 1'b0, 25'h000_0010, 8'hA0, 1'b0, 2'd0, 9'h000);
		add_entry(1'b0, 8'd0, "  ", 1'b0, 25'h000_4001, 8'hA1, 1'b0, 2'd0, 9'h100);
		add_entry(1'b0, 8'd0, "  ", 1'b0, 25'h000_BFFF, 8'hA2, 1'b0, 2'd0, 9'h107);
		add_entry(1'b0, 8'd0, "  ", 1'b0, 25'h000_C123, 8'hA3, 1'b0, 2'd0, 9'h0FF);
		add_entry(1'b0, 8'd0, "  ", 1'b0, 25'h001_0000, 8'hA4, 1'b0, 2'd1, 9'h000);
		add_entry(1'b0, 8'd0, "  ", 1'b0, 25'h001_6222, 8'hA5, 1'b0, 2'd1, 9'h100);
		add_entry(1'b0, 8'd0, "  ", 1'b0, 25'h001_8005, 8'hA6, 1'b0, 2'd1, 9'h107);
		add_entry(1'b0, 8'd0, "  ", 1'b0, 25'h001_FFFE, 8'hA7, 1'b0, 2'd1, 9'h0FF);
		add_entry(1'b0, 8'd0, "  ", 1'b0, 25'h002_0007, 8'hA8, 1'b1, 2'd0, 9'h000); // Block 8
		add_entry(1'b0, 8'd0, "  ", 1'b0, 25'h000_0011, 8'hA9, 1'b0, 2'd0, 9'h000);
		// Other download slot, acked only
		add_entry(1'b1, 8'd1, "  ", 1'b0, 25'h000_0000, 8'h50, 1'b1, 2'd0, 9'h000);
		add_entry(1'b0, 8'd1, "  ", 1'b0, 25'h000_0001, 8'h51, 1'b1, 2'd0, 9'h000);
		// Expansion pages, bank follows the model
		add_entry(1'b1, 8'd3, "07", 1'b1, 25'h000_0000, 8'h60, 1'b0, 2'd1, 9'h107);
		add_entry(1'b0, 8'd3, "07", 1'b1, 25'h000_8010, 8'h61, 1'b0, 2'd1, 9'h109);
		add_entry(1'b0, 8'd3, "07", 1'b1, 25'h000_4004, 8'h62, 1'b0, 2'd1, 9'h108);
		add_entry(1'b1, 8'd3, "A5", 1'b0, 25'h000_0003, 8'h70, 1'b0, 2'd0, 9'h1A5);
		add_entry(1'b1, 8'd3, "QQ", 1'b0, 25'h000_0002, 8'h80, 1'b0, 2'd0, 9'h1EE); // Malformed
		add_entry(1'b0, 8'd3, "QQ", 1'b0, 25'h000_4002, 8'h81, 1'b0, 2'd0, 9'h1EF);
		add_entry(1'b1, 8'd3, "ZZ", 1'b1, 25'h000_0009, 8'h90, 1'b0, 2'd1, 9'h000);
		add_entry(1'b0, 8'd3, "ZZ", 1'b1, 25'h000_4009, 8'h91, 1'b0, 2'd1, 9'h001);
		// Combo image jumps to the upper half after block 0
		add_entry(1'b1, 8'd3, "Z0", 1'b0, 25'h000_0000, 8'hC0, 1'b0, 2'd0, 9'h000);
		add_entry(1'b0, 8'd3, "Z0", 1'b0, 25'h000_3FFF, 8'hC1, 1'b0, 2'd0, 9'h000);
		add_entry(1'b0, 8'd3, "Z0", 1'b0, 25'h000_4000, 8'hC2, 1'b0, 2'd0, 9'h100);
		add_entry(1'b0, 8'd3, "Z0", 1'b0, 25'h000_8001, 8'hC3, 1'b0, 2'd0, 9'h101);
	endtask

	task automatic build_expected();
		mem_cmd_t c;
		exp_map = '0;
		foreach (stim_q[i]) begin
			if (!stim_q[i].drop) begin
				c.bank = stim_q[i].bank;
				c.addr = {stim_q[i].page, stim_q[i].addr[`LDR_BLOCK_W-1:0]}; // Page, then offset
				c.data = stim_q[i].data;
				exp_q.push_back(c);
				if (stim_q[i].page[`LDR_PAGE_W-1])
					exp_map[stim_q[i].page[7:0]] = 1'b1;
			end
		end
	endtask

	//////////////////////////////
	// Host model
	//////////////////////////////

	task automatic start_download(input logic [7:0] index, input logic [15:0] ext, input logic model);
		@(posedge clk_sys);
		host_download <= 1'b0;
		@(posedge clk_sys);
		host_index <= index;
		host_ext   <= ext;
		model_664  <= model;
		@(posedge clk_sys);
		host_download <= 1'b1;
		repeat (2) @(posedge clk_sys); // Let the intake classify first
	endtask

	task automatic send_byte(input logic [`LDR_HOST_ADDR_W-1:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		host_beat.addr <= addr;
		host_beat.data <= data;
		host_req       <= 1'b1;
		@(negedge clk_sys);
		while (!host_ack)
			@(negedge clk_sys);
		@(posedge clk_sys);
		host_req <= 1'b0;
		@(negedge clk_sys);
		while (host_ack)
			@(negedge clk_sys);
	endtask

	//////////////////////////////
	// Memory model and checker
	//////////////////////////////

	initial begin
		int delay;
		mem_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (mem_req && !mem_ack) begin
				got_q.push_back(mem_cmd);
				delay = $random(seed) & 7;
				repeat (delay) @(posedge clk_sys);
				@(posedge clk_sys);
				mem_ack <= 1'b1;
				@(negedge clk_sys);
				while (mem_req)
					@(negedge clk_sys);
				delay = $random(seed) & 7;
				repeat (delay) @(posedge clk_sys);
				@(posedge clk_sys);
				mem_ack <= 1'b0;
			end
		end
	end

	initial begin
		mem_cmd_t got;
		forever begin
			@(negedge clk_sys);
			while (got_q.size() > 0) begin
				got = got_q.pop_front();
				if (n_checked >= exp_q.size()) begin
					$display("memory got a command that no table entry expects, address %0h", got.addr);
					stop_run();
				end else begin
					check_value($sformatf("mem_cmd.bank #%0d", n_checked), 32'(got.bank),
						32'(exp_q[n_checked].bank));
					check_value($sformatf("mem_cmd.addr #%0d", n_checked), 32'(got.addr),
						32'(exp_q[n_checked].addr));
					check_value($sformatf("mem_cmd.data #%0d", n_checked), 32'(got.data),
						32'(exp_q[n_checked].data));
					n_checked++;
				end
			end
		end
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		reset         = 1'b1;
		host_download = 1'b0;
		host_index    = 8'd0;
		host_ext      = 16'd0;
		model_664     = 1'b0;
		host_req      = 1'b0;
		host_beat     = '0;
		load_table();
		build_expected();
		limit = stim_q.size() * CYCLES_PER_ENTRY + 200;
		fork
			begin
				repeat (limit) @(posedge clk_sys);
				$display("timeout, the memory commands did not all arrive in time");
				stop_run();
			end
		join_none
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		foreach (stim_q[i]) begin
			if (stim_q[i].new_dl)
				start_download(stim_q[i].index, stim_q[i].ext, stim_q[i].model);
			send_byte(stim_q[i].addr, stim_q[i].data);
		end
		@(posedge clk_sys);
		host_download <= 1'b0;
		while (n_checked < exp_q.size())
			@(negedge clk_sys);
		repeat (40) @(negedge clk_sys); // Time for a repeated command to show up
		for (int k = 0; k < `LDR_ROM_MAP_W / 32; k++)
			check_value($sformatf("rom_map[%0d+:32]", k * 32), rom_map[k*32 +: 32],
				exp_map[k*32 +: 32]);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: amstrad_loader.f
+incdir+hw
hw/loader_pkg.sv
hw/loader_intake.sv
hw/loader_addr_map.sv
hw/loader_mem_port.sv
hw/amstrad_loader.sv
test/loader_assertions.sv
test/tb_amstrad_loader.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the loader testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_amstrad_loader -f amstrad_loader.f \
	|| { echo "Build failed"; exit 1; }

./obj_dir/Vtb_amstrad_loader > sim.log 2>&1
sim_status=$?
cat sim.log

[ "$sim_status" -eq 0 ] && ! grep -qF '*** FAILED ***' sim.log \
	&& echo "Simulation run is clean" \
	|| { echo "Simulation reported a failure, see sim.log"; exit 1; }
